//--- common/xlate_pkg.sv
`default_nettype none

package xlate_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] ppn_t;
    typedef logic [19:0] vppn_t;
    typedef logic [16:0] ptag_t;
    typedef logic [2:0]  vseg_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [4:0]  tlb_idx_t;
    typedef logic [5:0]  page_size_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam int NUM_SEGS = 8;
    localparam page_size_t PS_4K = 6'd12;

    // from bit 0 up: plv, da, datm
    typedef struct packed {
        mat_t datm;
        logic da;
        plv_t plv;
    } crmd_t;

    // from bit 0 up: mat, pseg, vseg
    typedef struct packed {
        vseg_t vseg;
        vseg_t pseg;
        mat_t  mat;
    } dmw_t;

    typedef struct packed {
        crmd_t crmd;
        dmw_t  dmw0;
        dmw_t  dmw1;
    } csr_t;

    typedef struct packed {
        ppn_t ppn;
        logic v;
        logic d;
        mat_t mat;
        plv_t plv;
    } tlb_value_t;

    typedef struct packed {
        logic       e;
        vppn_t      vppn;
        tlb_value_t value;
    } tlb_entry_t;

    // dmw slots carry pseg in ppn[19:17]
    typedef struct packed {
        logic       dmw;
        logic       found;
        tlb_idx_t   index;
        page_size_t ps;
        tlb_value_t value;
    } tlb_s_resp_t;

    typedef enum logic [1:0] {
        FAULT_NONE = 2'd0,
        FAULT_TLBR = 2'd1,
        FAULT_PIL  = 2'd2,
        FAULT_PPI  = 2'd3
    } fault_e;

    typedef struct packed {
        paddr_t paddr;
        mat_t   mat;
        fault_e fault;
    } xlate_rsp_t;

    // apb register map
    localparam apb_addr_t REG_CRMD   = 8'h00;
    localparam apb_addr_t REG_DMW0   = 8'h04;
    localparam apb_addr_t REG_DMW1   = 8'h08;
    localparam apb_addr_t REG_TLBEHI = 8'h0C;
    localparam apb_addr_t REG_TLBELO = 8'h10;
    localparam apb_addr_t REG_TLBIDX = 8'h14;

    // exists bit of TLBIDX, index sits in the low bits
    localparam int TLBIDX_E_BIT = 31;

endpackage

`default_nettype wire

//--- daddr_trans/daddr_trans.sv
`default_nettype none

module daddr_trans (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_i,
    input  xlate_pkg::vaddr_t      vaddr_i,
    input  logic                   m1_stall_i,
    output logic                   ready_o,
    input  xlate_pkg::csr_t        csr_i,
    input  logic                   flush_trans_i,
    output logic                   tlb_req_valid_o,
    input  logic                   tlb_req_ready_i,
    input  xlate_pkg::tlb_s_resp_t tlb_resp_i,
    output logic                   m1_valid_o,
    output xlate_pkg::vaddr_t      m1_vaddr_o,
    output xlate_pkg::tlb_s_resp_t tlb_raw_result_o
);
    import xlate_pkg::*;

    typedef enum logic [3:0] {
        ST_NORMAL = 4'b0001,
        ST_DMW0   = 4'b0010,
        ST_DMW1   = 4'b0100,
        ST_TLB    = 4'b1000
    } fsm_e;

    logic [NUM_SEGS-1:0] slot_valid_q;
    logic [NUM_SEGS-1:0] slot_istlb_q;
    ptag_t               slot_tag_q [NUM_SEGS];
    tlb_s_resp_t         slot_resp_q [NUM_SEGS];

    fsm_e        fsm_q;
    fsm_e        fsm_d;
    logic        da_mode;
    vseg_t       ex_seg;
    logic        m1_valid_q;
    logic        m1_hit_q;
    logic        m1_istlb_q;
    logic        m1_tag_miss_q;
    vaddr_t      m1_vaddr_q;
    tlb_s_resp_t m1_result_q;
    logic        m1_miss;
    logic        slot_we;
    vseg_t       slot_idx;
    logic        slot_istlb;
    tlb_s_resp_t slot_resp;

    // window looks like a found, valid 4K page
    function automatic tlb_s_resp_t dmw_resp(input dmw_t dmw);
        tlb_s_resp_t r;
        r           = '0;
        r.dmw       = 1'b1;
        r.found     = 1'b1;
        r.ps        = PS_4K;
        r.value.ppn = {dmw.pseg, 17'b0};
        r.value.v   = 1'b1;
        r.value.d   = 1'b1;
        r.value.mat = dmw.mat;
        return r;
    endfunction

    assign da_mode = csr_i.crmd.da;
    assign ex_seg  = vaddr_i[31:29];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid_q    <= 1'b0;
            m1_hit_q      <= 1'b1;
            m1_istlb_q    <= 1'b0;
            m1_tag_miss_q <= 1'b0;
        end else if (!m1_stall_i) begin
            m1_valid_q    <= valid_i;
            // bubbles and DA mode never miss
            m1_hit_q      <= slot_valid_q[ex_seg] || !valid_i || da_mode;
            m1_istlb_q    <= slot_istlb_q[ex_seg] && valid_i && !da_mode;
            m1_tag_miss_q <= slot_tag_q[ex_seg] != vaddr_i[28:12];
        end else if (m1_miss) begin
            m1_hit_q      <= tlb_req_ready_i;
            m1_istlb_q    <= tlb_req_ready_i;
            m1_tag_miss_q <= !tlb_req_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!m1_stall_i) begin
            m1_vaddr_q  <= vaddr_i;
            m1_result_q <= slot_resp_q[ex_seg];
        end else if (m1_miss && tlb_req_ready_i) begin
            m1_result_q <= tlb_resp_i;
        end
    end

    assign m1_miss = !m1_hit_q || (m1_istlb_q && m1_tag_miss_q);

    // refill fsm
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm_q <= ST_NORMAL;
        end else begin
            fsm_q <= fsm_d;
        end
    end

    always_comb begin
        fsm_d = fsm_q;
        if (flush_trans_i) begin
            fsm_d = ST_DMW0;
        end else begin
            case (fsm_q)
                ST_DMW0: fsm_d = ST_DMW1;
                ST_DMW1: fsm_d = ST_NORMAL;
                ST_TLB: begin
                    if (tlb_req_ready_i) begin
                        fsm_d = ST_NORMAL;
                    end
                end
                default: begin
                    if (m1_miss) begin
                        fsm_d = ST_TLB;
                    end
                end
            endcase
        end
    end

    always_comb begin
        slot_we    = 1'b0;
        slot_idx   = m1_vaddr_q[31:29];
        slot_istlb = 1'b0;
        slot_resp  = tlb_resp_i;
        case (fsm_q)
            ST_DMW0: begin
                slot_we   = 1'b1;
                slot_idx  = csr_i.dmw0.vseg;
                slot_resp = dmw_resp(csr_i.dmw0);
            end
            ST_DMW1: begin
                slot_we   = 1'b1;
                slot_idx  = csr_i.dmw1.vseg;
                slot_resp = dmw_resp(csr_i.dmw1);
            end
            ST_TLB: begin
                slot_we    = tlb_req_ready_i;
                slot_istlb = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_trans_i) begin
            slot_valid_q <= '0;
        end else if (slot_we) begin
            slot_valid_q[slot_idx] <= 1'b1;
        end
    end

    // tag only matters for tlb slots
    always_ff @(posedge clk) begin
        if (slot_we) begin
            slot_istlb_q[slot_idx] <= slot_istlb;
            slot_tag_q[slot_idx]   <= m1_vaddr_q[28:12];
            slot_resp_q[slot_idx]  <= slot_resp;
        end
    end

    assign ready_o          = !m1_miss;
    assign tlb_req_valid_o  = (fsm_q == ST_TLB);
    assign m1_valid_o       = m1_valid_q;
    assign m1_vaddr_o       = m1_vaddr_q;
    assign tlb_raw_result_o = m1_result_q;

endmodule

`default_nettype wire

//--- daddr_xlate.f
+incdir+dv
common/xlate_pkg.sv
verilog/xlate_csr_apb.sv
daddr_trans/daddr_trans.sv
verilog/tlb_lookup.sv
verilog/daddr_result.sv
verilog/daddr_xlate_top.sv
dv/daddr_xlate_tb.sv

//--- dv/daddr_xlate_tests.svh
`ifndef DADDR_XLATE_TESTS_SVH
`define DADDR_XLATE_TESTS_SVH

task automatic regs_readback();
    apb_data_t  data;
    logic       err;
    tlb_value_t val;
    val = make_page(20'h5_4321, 1'b1, 2'd1, 2'd2);
    write_crmd(2'd1, 1'b0, 2'd2);
    write_dmw(1'b0, 3'd4, 3'd2, 2'd1);
    write_dmw(1'b1, 3'd5, 3'd7, 2'd0);
    write_tlb(7, 1'b1, 20'h7_0000, val);
    apb_read(REG_CRMD, data, err);
    check_data("crmd readback", data, apb_data_t'(model_crmd));
    check_data("crmd pslverr", apb_data_t'(err), 32'd0);
    apb_read(REG_DMW0, data, err);
    check_data("dmw0 readback", data, apb_data_t'(model_dmw0));
    apb_read(REG_DMW1, data, err);
    check_data("dmw1 readback", data, apb_data_t'(model_dmw1));
    apb_read(REG_TLBEHI, data, err);
    check_data("tlbehi readback", data, {20'h7_0000, 12'h000});
    apb_read(REG_TLBELO, data, err);
    check_data("tlbelo readback", data, apb_data_t'(val));
    apb_read(REG_TLBIDX, data, err);
    check_data("tlbidx readback", data, (32'd1 << TLBIDX_E_BIT) | 32'd7);
    // unmapped offset
    apb_read(8'h18, data, err);
    check_data("unmapped pslverr", apb_data_t'(err), 32'd1);
endtask

task automatic dmw_translation();
    write_dmw(1'b0, 3'd4, 3'd0, 2'd1);
    write_dmw(1'b1, 3'd5, 3'd1, 2'd0);
    translate(32'h8000_1234);
    translate(32'h9FFF_FFFC);
    translate(32'hA012_3458);
    translate(32'hBFFF_0000);
    drain_rsps("dmw");
endtask

task automatic tlb_refill_reuse();
    write_tlb(0, 1'b1, 20'h0_0012, make_page(20'h3_4567, 1'b1, 2'd1, 2'd3));
    write_tlb(1, 1'b1, 20'h0_0013, make_page(20'h0_ABCD, 1'b1, 2'd2, 2'd3));
    translate(32'h0001_2345);
    translate(32'h0001_2345);
    // other page in segment 0, tag mismatch
    translate(32'h0001_3ABC);
    translate(32'h0001_2FF0);
    drain_rsps("tlb");
endtask

task automatic page_faults();
    translate(32'h0005_5000);
    drain_rsps("absent page");
    write_tlb(2, 1'b1, 20'h0_0020, make_page(20'h1_1111, 1'b0, 2'd1, 2'd3));
    translate(32'h0002_0ABC);
    drain_rsps("invalid page");
    write_tlb(3, 1'b1, 20'h0_0030, make_page(20'h2_2222, 1'b1, 2'd1, 2'd0));
    write_crmd(2'd3, 1'b0, 2'd0);
    translate(32'h0003_0040);
    drain_rsps("privilege");
    write_crmd(2'd0, 1'b0, 2'd0);
endtask

task automatic direct_mode();
    write_crmd(2'd0, 1'b1, 2'd3);
    translate(32'h8000_0010);
    translate(32'h0001_2345);
    translate(32'hDEAD_BEE0);
    drain_rsps("da on");
    write_crmd(2'd0, 1'b0, 2'd3);
    translate(32'h8000_0010);
    translate(32'hDEAD_BEE0);
    drain_rsps("da off");
endtask

task automatic backpressure_flush();
    for (int burst = 0; burst < 2; burst++) begin
        if (burst == 1) begin
            write_dmw(1'b0, 3'd4, 3'd6, 2'd3);
        end
        @(posedge clk);
        #1;
        rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    translate(random_dmw_addr());
                end
            end
            begin
                repeat (20) @(posedge clk);
                #1;
                rsp_ready = 1'b1;
            end
        join
        drain_rsps($sformatf("burst %0d", burst));
    end
endtask

`endif

//--- dv/daddr_xlate_tb.sv
`default_nettype none

module daddr_xlate_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import xlate_pkg::*;

    localparam int TLB_ENTRIES = 8;
    // all tests together take about 600 cycles
    localparam int MAX_CYCLES = 3000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       req_valid;
    vaddr_t     req_vaddr;
    logic       req_ready;
    logic       rsp_valid;
    xlate_rsp_t rsp;
    logic       rsp_ready;

    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    // reference copy of the CSRs and TLB contents
    crmd_t      model_crmd;
    dmw_t       model_dmw0;
    dmw_t       model_dmw1;
    tlb_entry_t model_tlb [TLB_ENTRIES];

    xlate_rsp_t exp_q [$];
    xlate_rsp_t got_q [$];
    vaddr_t     addr_q [$];

    always #4 clk = ~clk;

    daddr_xlate_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_daddr_xlate_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .req_valid_i(req_valid),
        .req_vaddr_i(req_vaddr),
        .req_ready_o(req_ready),
        .rsp_valid_o(rsp_valid),
        .rsp_o      (rsp),
        .rsp_ready_i(rsp_ready)
    );

    // handshake completes on the next rising edge
    always @(negedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            got_q.push_back(rsp);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, %0d responses still missing",
                     cycle_count, exp_q.size() - got_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_rsp(input string what, input xlate_rsp_t got, input xlate_rsp_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got paddr %h mat %0d fault %0d", $time, what,
                     got.paddr, got.mat, got.fault);
            $display("    expected paddr %h mat %0d fault %0d", exp.paddr, exp.mat, exp.fault);
        end
    endtask

    task automatic check_data(input string what, input apb_data_t got, input apb_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_data("apb write pready", apb_data_t'(pready), 32'd1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // flush and both DMW reloads settle
        repeat (4) @(posedge clk);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_data("apb read pready", apb_data_t'(pready), 32'd1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_crmd(input plv_t plv, input logic da, input mat_t datm);
        model_crmd.plv  = plv;
        model_crmd.da   = da;
        model_crmd.datm = datm;
        apb_write(REG_CRMD, apb_data_t'(model_crmd));
    endtask

    task automatic write_dmw(input bit second, input vseg_t vseg, input vseg_t pseg,
                             input mat_t mat);
        dmw_t d;
        d.vseg = vseg;
        d.pseg = pseg;
        d.mat  = mat;
        if (second) begin
            model_dmw1 = d;
            apb_write(REG_DMW1, apb_data_t'(d));
        end else begin
            model_dmw0 = d;
            apb_write(REG_DMW0, apb_data_t'(d));
        end
    endtask

    function automatic tlb_value_t make_page(input ppn_t ppn, input logic v, input mat_t mat,
                                             input plv_t plv);
        tlb_value_t val;
        val.ppn = ppn;
        val.v   = v;
        val.d   = 1'b1;
        val.mat = mat;
        val.plv = plv;
        return val;
    endfunction

    task automatic write_tlb(input int idx, input logic e, input vppn_t vppn,
                             input tlb_value_t val);
        model_tlb[idx].e     = e;
        model_tlb[idx].vppn  = vppn;
        model_tlb[idx].value = val;
        apb_write(REG_TLBEHI, {vppn, 12'h000});
        apb_write(REG_TLBELO, apb_data_t'(val));
        apb_write(REG_TLBIDX, apb_data_t'(idx) | (apb_data_t'(e) << TLBIDX_E_BIT));
    endtask

    // DA first, then the windows (DMW1 loads last), then the TLB
    function automatic xlate_rsp_t model_xlate(input vaddr_t va);
        xlate_rsp_t r;
        tlb_value_t val;
        logic       found;
        r.fault = FAULT_NONE;
        found   = 1'b0;
        val     = '0;
        if (model_crmd.da) begin
            r.paddr = va;
            r.mat   = model_crmd.datm;
        end else if (va[31:29] == model_dmw1.vseg) begin
            r.paddr = {model_dmw1.pseg, va[28:0]};
            r.mat   = model_dmw1.mat;
        end else if (va[31:29] == model_dmw0.vseg) begin
            r.paddr = {model_dmw0.pseg, va[28:0]};
            r.mat   = model_dmw0.mat;
        end else begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (!found && model_tlb[i].e && model_tlb[i].vppn == va[31:12]) begin
                    found = 1'b1;
                    val   = model_tlb[i].value;
                end
            end
            r.paddr = {val.ppn, va[11:0]};
            r.mat   = val.mat;
            if (!found) begin
                r.fault = FAULT_TLBR;
            end else if (!val.v) begin
                r.fault = FAULT_PIL;
            end else if (model_crmd.plv > val.plv) begin
                r.fault = FAULT_PPI;
            end
        end
        return r;
    endfunction

    task automatic send_req(input vaddr_t addr);
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_vaddr = addr;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic translate(input vaddr_t addr);
        exp_q.push_back(model_xlate(addr));
        addr_q.push_back(addr);
        send_req(addr);
    endtask

    task automatic drain_rsps(input string what);
        xlate_rsp_t got;
        xlate_rsp_t exp;
        vaddr_t     addr;
        while (got_q.size() < exp_q.size()) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        if (got_q.size() != exp_q.size()) begin
            error_count++;
            $display("%s: %0d responses arrived for %0d requests", what, got_q.size(),
                     exp_q.size());
        end
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            addr = addr_q.pop_front();
            check_rsp($sformatf("%s vaddr %h", what, addr), got, exp);
        end
        got_q.delete();
        exp_q.delete();
        addr_q.delete();
    endtask

    function automatic vaddr_t random_dmw_addr();
        vseg_t seg;
        seg = ($urandom & 1) ? model_dmw1.vseg : model_dmw0.vseg;
        return {seg, 29'($urandom)};
    endfunction

    `include "daddr_xlate_tests.svh"

    initial begin
        void'($urandom(32'h228));
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        rsp_ready  = 1'b1;
        model_crmd = '0;
        model_dmw0 = '0;
        model_dmw1 = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_tlb[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        regs_readback();
        dmw_translation();
        tlb_refill_reuse();
        page_faults();
        direct_mode();
        backpressure_flush();

        repeat (5) @(posedge clk);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run from the project root

verilator --binary --timing --top-module daddr_xlate_tb -f daddr_xlate.f \
    -o daddr_xlate_sim || exit 1

./obj_dir/daddr_xlate_sim > sim.log 2>&1
cat sim.log

grep -qxF '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verilog/daddr_result.sv
`default_nettype none

module daddr_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   m1_valid_i,
    input  logic                   m1_stall_i,
    input  xlate_pkg::vaddr_t      vaddr_i,
    input  xlate_pkg::tlb_s_resp_t tlb_resp_i,
    input  xlate_pkg::csr_t        csr_i,
    input  logic                   rsp_ready_i,
    output logic                   rsp_valid_o,
    output xlate_pkg::xlate_rsp_t  rsp_o,
    output logic                   full_o
);
    import xlate_pkg::*;

    logic       rsp_valid_q;
    xlate_rsp_t rsp_q;
    xlate_rsp_t rsp_d;
    logic       load;

    assign load = m1_valid_i && !m1_stall_i;

    always_comb begin
        rsp_d.fault = FAULT_NONE;
        if (csr_i.crmd.da) begin
            rsp_d.paddr = vaddr_i;
            rsp_d.mat   = csr_i.crmd.datm;
        end else if (tlb_resp_i.dmw) begin
            rsp_d.paddr = {tlb_resp_i.value.ppn[19:17], vaddr_i[28:0]};
            rsp_d.mat   = tlb_resp_i.value.mat;
        end else begin
            rsp_d.paddr = {tlb_resp_i.value.ppn, vaddr_i[11:0]};
            rsp_d.mat   = tlb_resp_i.value.mat;
            // page checks, most severe first
            if (!tlb_resp_i.found) begin
                rsp_d.fault = FAULT_TLBR;
            end else if (!tlb_resp_i.value.v) begin
                rsp_d.fault = FAULT_PIL;
            end else if (csr_i.crmd.plv > tlb_resp_i.value.plv) begin
                rsp_d.fault = FAULT_PPI;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (!rsp_valid_q || rsp_ready_i) begin
            rsp_valid_q <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign full_o      = rsp_valid_q;

endmodule

`default_nettype wire

//--- verilog/daddr_xlate_top.sv
`default_nettype none

module daddr_xlate_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  xlate_pkg::apb_addr_t  paddr_i,
    input  xlate_pkg::apb_data_t  pwdata_i,
    output xlate_pkg::apb_data_t  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  req_valid_i,
    input  xlate_pkg::vaddr_t     req_vaddr_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output xlate_pkg::xlate_rsp_t rsp_o,
    input  logic                  rsp_ready_i
);
    import xlate_pkg::*;

    csr_t        csr;
    logic        flush_trans;
    logic        tlb_we;
    tlb_idx_t    tlb_widx;
    tlb_entry_t  tlb_wentry;
    logic        tlb_req_valid;
    logic        tlb_req_ready;
    tlb_s_resp_t tlb_resp;
    logic        m1_valid;
    vaddr_t      m1_vaddr;
    tlb_s_resp_t m1_resp;
    logic        m1_ready;
    logic        rsp_full;
    logic        m1_stall;

    // hold M1 on a refill or on a response not yet taken
    assign m1_stall    = !m1_ready || (rsp_full && !rsp_ready_i);
    assign req_ready_o = !m1_stall;

    xlate_csr_apb i_xlate_csr_apb (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .csr_o        (csr),
        .flush_trans_o(flush_trans),
        .tlb_we_o     (tlb_we),
        .tlb_widx_o   (tlb_widx),
        .tlb_wentry_o (tlb_wentry)
    );

    daddr_trans i_daddr_trans (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_i         (req_valid_i),
        .vaddr_i         (req_vaddr_i),
        .m1_stall_i      (m1_stall),
        .ready_o         (m1_ready),
        .csr_i           (csr),
        .flush_trans_i   (flush_trans),
        .tlb_req_valid_o (tlb_req_valid),
        .tlb_req_ready_i (tlb_req_ready),
        .tlb_resp_i      (tlb_resp),
        .m1_valid_o      (m1_valid),
        .m1_vaddr_o      (m1_vaddr),
        .tlb_raw_result_o(m1_resp)
    );

    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_tlb_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .we_i       (tlb_we),
        .widx_i     (tlb_widx),
        .wentry_i   (tlb_wentry),
        .req_valid_i(tlb_req_valid),
        .req_vppn_i (m1_vaddr[31:12]),
        .req_ready_o(tlb_req_ready),
        .resp_o     (tlb_resp)
    );

    daddr_result i_daddr_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .m1_valid_i (m1_valid),
        .m1_stall_i (m1_stall),
        .vaddr_i    (m1_vaddr),
        .tlb_resp_i (m1_resp),
        .csr_i      (csr),
        .rsp_ready_i(rsp_ready_i),
        .rsp_valid_o(rsp_valid_o),
        .rsp_o      (rsp_o),
        .full_o     (rsp_full)
    );

endmodule

`default_nettype wire

//--- verilog/tlb_lookup.sv
`default_nettype none

module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we_i,
    input  xlate_pkg::tlb_idx_t    widx_i,
    input  xlate_pkg::tlb_entry_t  wentry_i,
    input  logic                   req_valid_i,
    input  xlate_pkg::vppn_t       req_vppn_i,
    output logic                   req_ready_o,
    output xlate_pkg::tlb_s_resp_t resp_o
);
    import xlate_pkg::*;

    localparam int IW = $clog2(TLB_ENTRIES);

    tlb_entry_t  entries_q [TLB_ENTRIES];
    logic        hit;
    tlb_idx_t    hit_idx;
    tlb_value_t  hit_value;
    logic        ready_q;
    tlb_s_resp_t resp_q;

    // out-of-range index writes are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries_q[i].e <= 1'b0;
            end
        end else if (we_i && int'(widx_i) < TLB_ENTRIES) begin
            entries_q[widx_i[IW-1:0]] <= wentry_i;
        end
    end

    // walk downward so the lowest match wins
    always_comb begin
        hit       = 1'b0;
        hit_idx   = '0;
        hit_value = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries_q[i].e && entries_q[i].vppn == req_vppn_i) begin
                hit       = 1'b1;
                hit_idx   = tlb_idx_t'(i);
                hit_value = entries_q[i].value;
            end
        end
    end

    // one strobe per request, no accept while answering
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= req_valid_i && !ready_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && !ready_q) begin
            resp_q.dmw   <= 1'b0;
            resp_q.found <= hit;
            resp_q.index <= hit_idx;
            resp_q.ps    <= PS_4K;
            resp_q.value <= hit_value;
        end
    end

    assign req_ready_o = ready_q;
    assign resp_o      = resp_q;

endmodule

`default_nettype wire

//--- verilog/xlate_csr_apb.sv
`default_nettype none

module xlate_csr_apb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  xlate_pkg::apb_addr_t  paddr_i,
    input  xlate_pkg::apb_data_t  pwdata_i,
    output xlate_pkg::apb_data_t  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output xlate_pkg::csr_t       csr_o,
    output logic                  flush_trans_o,
    output logic                  tlb_we_o,
    output xlate_pkg::tlb_idx_t   tlb_widx_o,
    output xlate_pkg::tlb_entry_t tlb_wentry_o
);
    import xlate_pkg::*;

    csr_t       csr_q;
    vppn_t      tlbehi_q;
    tlb_value_t tlbelo_q;
    logic       tlbidx_e_q;
    tlb_idx_t   tlbidx_q;
    logic       flush_q;
    logic       tlb_we_q;
    logic       access;
    logic       wr_en;
    logic       mapped;

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_CRMD:   prdata_o[$bits(crmd_t)-1:0] = csr_q.crmd;
            REG_DMW0:   prdata_o[$bits(dmw_t)-1:0] = csr_q.dmw0;
            REG_DMW1:   prdata_o[$bits(dmw_t)-1:0] = csr_q.dmw1;
            REG_TLBEHI: prdata_o[31:12] = tlbehi_q;
            REG_TLBELO: prdata_o[$bits(tlb_value_t)-1:0] = tlbelo_q;
            REG_TLBIDX: begin
                prdata_o[TLBIDX_E_BIT] = tlbidx_e_q;
                prdata_o[$bits(tlb_idx_t)-1:0] = tlbidx_q;
            end
            default:    mapped = 1'b0;
        endcase
    end

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                REG_CRMD: csr_q.crmd <= pwdata_i[$bits(crmd_t)-1:0];
                REG_DMW0: csr_q.dmw0 <= pwdata_i[$bits(dmw_t)-1:0];
                REG_DMW1: csr_q.dmw1 <= pwdata_i[$bits(dmw_t)-1:0];
                default:  ;
            endcase
        end
    end

    // tlb staging
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr_i)
                REG_TLBEHI: tlbehi_q <= pwdata_i[31:12];
                REG_TLBELO: tlbelo_q <= pwdata_i[$bits(tlb_value_t)-1:0];
                REG_TLBIDX: begin
                    tlbidx_e_q <= pwdata_i[TLBIDX_E_BIT];
                    tlbidx_q   <= pwdata_i[$bits(tlb_idx_t)-1:0];
                end
                default:    ;
            endcase
        end
    end

    // both pulses land the cycle after the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q  <= 1'b0;
            tlb_we_q <= 1'b0;
        end else begin
            tlb_we_q <= wr_en && (paddr_i == REG_TLBIDX);
            flush_q  <= wr_en && (paddr_i inside {REG_CRMD, REG_DMW0, REG_DMW1, REG_TLBIDX});
        end
    end

    assign csr_o         = csr_q;
    assign flush_trans_o = flush_q;
    assign tlb_we_o      = tlb_we_q;
    assign tlb_widx_o    = tlbidx_q;
    assign tlb_wentry_o  = '{e: tlbidx_e_q, vppn: tlbehi_q, value: tlbelo_q};

endmodule

`default_nettype wire
